// File: build.f
rtl/eeprom_pkg.sv
rtl/serial_frame_engine.sv
rtl/eeprom_sequencer.sv
rtl/eeprom_ctrl_top.sv
verification/clk_reset_gen.sv
verification/eeprom_bus_model.sv
verification/tb_eeprom_ctrl.sv

// File: rtl/eeprom_ctrl_top.sv
module eeprom_ctrl_top #(
    parameter int SCL_HALF = 1   // CLK cycles per scl half period
) (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr,
    input  logic                     rd,
    input  eeprom_pkg::eeprom_addr_t addr,
    input  eeprom_pkg::eeprom_byte_t wr_data,
    output eeprom_pkg::eeprom_byte_t rd_data,
    output logic                     ack,
    output logic                     scl,
    inout  wire                      sda
);

    eeprom_pkg::frame_req_t   frame_req;
    logic                     frame_go;
    logic                     frame_done;
    eeprom_pkg::eeprom_byte_t rx_byte;

    eeprom_sequencer seq (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wr_data    (wr_data),
        .rd_data    (rd_data),
        .ack        (ack),
        .frame_req  (frame_req),
        .frame_go   (frame_go),
        .frame_done (frame_done),
        .rx_byte    (rx_byte)
    );

    serial_frame_engine #(
        .SCL_HALF (SCL_HALF)
    ) engine (
        .CLK        (CLK),
        .RESET      (RESET),
        .frame_req  (frame_req),
        .frame_go   (frame_go),
        .frame_done (frame_done),
        .rx_byte    (rx_byte),
        .scl        (scl),
        .sda        (sda)
    );

endmodule

// File: rtl/eeprom_pkg.sv
package eeprom_pkg;

    // byte address into the 2 KB array
    typedef logic [10:0] eeprom_addr_t;

    // data, control and address bytes on the wire
    typedef logic [7:0] eeprom_byte_t;

    // one bus frame, start also serves as repeated start
    typedef enum logic [1:0] {
        frame_start,
        frame_stop,
        frame_tx,
        frame_rx
    } frame_kind_e;

    // sequencer to engine, payload only meaningful for frame_tx
    typedef struct packed {
        frame_kind_e  kind;
        eeprom_byte_t payload;
    } frame_req_t;

    // device type code, upper nibble of every control byte
    localparam logic [3:0] DEV_PREFIX = 4'b1010;

endpackage

// File: rtl/eeprom_sequencer.sv
module eeprom_sequencer (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr,
    input  logic                     rd,
    input  eeprom_pkg::eeprom_addr_t addr,
    input  eeprom_pkg::eeprom_byte_t wr_data,
    output eeprom_pkg::eeprom_byte_t rd_data,
    output logic                     ack,
    output eeprom_pkg::frame_req_t   frame_req,
    output logic                     frame_go,
    input  logic                     frame_done,
    input  eeprom_pkg::eeprom_byte_t rx_byte
);

    typedef enum logic [3:0] {
        s_idle,
        s_start,
        s_ctrl_wr,
        s_addr,
        s_data,
        s_restart,
        s_ctrl_rd,
        s_read,
        s_stop,
        s_done
    } state_e;

    state_e                   state;
    logic                     is_read;
    eeprom_pkg::eeprom_addr_t addr_q;
    eeprom_pkg::eeprom_byte_t data_q;

    // prefix, block bits, direction
    function automatic eeprom_pkg::eeprom_byte_t ctrl_byte(input logic rd_dir);
        return {eeprom_pkg::DEV_PREFIX, addr_q[10:8], rd_dir};
    endfunction

    function automatic eeprom_pkg::frame_req_t make_req(
        input eeprom_pkg::frame_kind_e  kind,
        input eeprom_pkg::eeprom_byte_t payload
    );
        eeprom_pkg::frame_req_t req;
        req.kind    = kind;
        req.payload = payload;
        return req;
    endfunction

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= s_idle;
            frame_go <= 1'b0;
            ack      <= 1'b0;
        end
        else
        begin
            frame_go <= 1'b0;
            ack      <= 1'b0;
            case (state)
                s_idle:
                    if (wr || rd)
                    begin
                        is_read   <= !wr;      // write wins when both are up
                        addr_q    <= addr;
                        data_q    <= wr_data;
                        state     <= s_start;
                        frame_go  <= 1'b1;
                        frame_req <= make_req(eeprom_pkg::frame_start, '0);
                    end
                s_start:
                    if (frame_done)
                    begin
                        state     <= s_ctrl_wr;
                        frame_go  <= 1'b1;
                        frame_req <= make_req(eeprom_pkg::frame_tx, ctrl_byte(1'b0));
                    end
                s_ctrl_wr:
                    if (frame_done)
                    begin
                        state     <= s_addr;
                        frame_go  <= 1'b1;
                        frame_req <= make_req(eeprom_pkg::frame_tx, addr_q[7:0]);
                    end
                s_addr:
                    if (frame_done)
                    begin
                        frame_go <= 1'b1;
                        if (is_read)
                        begin
                            state     <= s_restart;
                            frame_req <= make_req(eeprom_pkg::frame_start, '0);
                        end
                        else
                        begin
                            state     <= s_data;
                            frame_req <= make_req(eeprom_pkg::frame_tx, data_q);
                        end
                    end
                s_data:
                    if (frame_done)
                    begin
                        state     <= s_stop;
                        frame_go  <= 1'b1;
                        frame_req <= make_req(eeprom_pkg::frame_stop, '0);
                    end
                s_restart:
                    if (frame_done)
                    begin
                        state     <= s_ctrl_rd;
                        frame_go  <= 1'b1;
                        frame_req <= make_req(eeprom_pkg::frame_tx, ctrl_byte(1'b1));
                    end
                s_ctrl_rd:
                    if (frame_done)
                    begin
                        state     <= s_read;
                        frame_go  <= 1'b1;
                        frame_req <= make_req(eeprom_pkg::frame_rx, '0);
                    end
                s_read:
                    if (frame_done)
                    begin
                        state     <= s_stop;
                        frame_go  <= 1'b1;
                        frame_req <= make_req(eeprom_pkg::frame_stop, '0);
                    end
                s_stop:
                    if (frame_done)
                    begin
                        state <= s_done;
                        ack   <= 1'b1;
                        if (is_read)
                            rd_data <= rx_byte;   // engine holds last rx byte
                    end
                s_done:
                    state <= s_idle;   // ack high here, no request taken
                default:
                    state <= s_idle;
            endcase
        end
    end

    ack_single_cycle: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack);

endmodule

// File: rtl/serial_frame_engine.sv
module serial_frame_engine #(
    parameter int SCL_HALF = 1
) (
    input  logic                     CLK,
    input  logic                     RESET,
    input  eeprom_pkg::frame_req_t   frame_req,
    input  logic                     frame_go,
    output logic                     frame_done,
    output eeprom_pkg::eeprom_byte_t rx_byte,
    output logic                     scl,
    inout  wire                      sda
);

    localparam int HALF_W    = $clog2(SCL_HALF + 1);
    localparam int SAMPLE_AT = (SCL_HALF - 1) / 2; // middle of scl high

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_bit_low,
        st_bit_high,
        st_stop,
        st_finish
    } state_e;

    state_e                   state;
    eeprom_pkg::frame_kind_e  kind;
    eeprom_pkg::eeprom_byte_t shift;
    logic [HALF_W-1:0]        half_cnt;
    logic [2:0]               bit_cnt;   // bit index, or phase of start/stop
    logic                     sda_d;
    logic                     oe_d;
    logic                     sda_q;
    logic                     oe_q;
    logic                     half_end;
    logic                     sda_en;

    assign half_end = (half_cnt == HALF_W'(SCL_HALF - 1));

    // drive begins half a CLK late, release is immediate
    assign sda_en = oe_d && oe_q;
    assign sda    = sda_en ? sda_q : 1'bz;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= st_idle;
            scl        <= 1'b1;
            oe_d       <= 1'b0;
            frame_done <= 1'b0;
            half_cnt   <= '0;
            bit_cnt    <= '0;
        end
        else
        begin
            frame_done <= 1'b0;
            if (state == st_idle || state == st_finish)
                half_cnt <= '0;
            else
                half_cnt <= half_end ? '0 : half_cnt + 1'b1;

            case (state)
                st_idle:
                    if (frame_go)
                    begin
                        kind    <= frame_req.kind;
                        bit_cnt <= '0;
                        scl     <= 1'b0;   // every frame opens with scl low
                        case (frame_req.kind)
                            eeprom_pkg::frame_start:
                            begin
                                state <= st_start;
                                oe_d  <= 1'b1;
                                sda_d <= 1'b1;
                            end
                            eeprom_pkg::frame_stop:
                            begin
                                state <= st_stop;
                                oe_d  <= 1'b1;
                                sda_d <= 1'b0;
                            end
                            eeprom_pkg::frame_tx:
                            begin
                                state <= st_bit_low;
                                oe_d  <= 1'b1;
                                sda_d <= frame_req.payload[7];
                                shift <= frame_req.payload;
                            end
                            default:
                            begin
                                state <= st_bit_low;
                                oe_d  <= 1'b0; // memory owns sda
                            end
                        endcase
                    end
                st_start:
                    if (half_end)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        case (bit_cnt[1:0])
                            2'd0:    scl   <= 1'b1;
                            2'd1:    sda_d <= 1'b0;  // falls with scl high
                            2'd2:    scl   <= 1'b0;
                            default: state <= st_finish;
                        endcase
                    end
                st_stop:
                    if (half_end)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt[1:0] == 2'd0)
                            scl <= 1'b1;
                        if (bit_cnt[1:0] == 2'd1)
                            sda_d <= 1'b1;             // rises with scl high
                        if (bit_cnt[1:0] == 2'd3)
                            state <= st_finish;
                    end
                st_bit_low:
                    if (half_end)
                    begin
                        state <= st_bit_high;
                        scl   <= 1'b1;
                    end
                st_bit_high:
                begin
                    if (kind == eeprom_pkg::frame_rx && half_cnt == HALF_W'(SAMPLE_AT))
                        shift <= {shift[6:0], sda};
                    if (half_end)
                    begin
                        if (bit_cnt == 3'd7)
                            state <= st_finish;
                        else
                        begin
                            state   <= st_bit_low;
                            scl     <= 1'b0;
                            bit_cnt <= bit_cnt + 1'b1;
                            if (kind == eeprom_pkg::frame_tx)
                            begin
                                shift <= {shift[6:0], 1'b0};
                                sda_d <= shift[6];     // msb first
                            end
                        end
                    end
                end
                st_finish:
                begin
                    state      <= st_idle;
                    frame_done <= 1'b1;
                    if (kind == eeprom_pkg::frame_stop)
                        oe_d <= 1'b0;                  // bus free, pull-up holds high
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    // sda moves half a CLK after scl so edges never coincide
    always_ff @(negedge CLK)
    begin
        if (RESET)
            oe_q <= 1'b0;
        else
            oe_q <= oe_d;
        sda_q <= sda_d;
    end

    always_ff @(posedge CLK)
    begin
        if (state == st_finish && kind == eeprom_pkg::frame_rx)
            rx_byte <= shift;
    end

    go_only_when_idle: assert property (@(posedge CLK) disable iff (RESET)
        frame_go |-> state == st_idle);

    rx_never_drives: assert property (@(posedge CLK) disable iff (RESET)
        (state != st_idle && kind == eeprom_pkg::frame_rx) |-> !sda_en);

endmodule

// File: verification/clk_reset_gen.sv
module clk_reset_gen (
    output logic CLK,
    output logic RESET
);

    initial
    begin
        CLK   = 1'b0;
        RESET = 1'b1;
        repeat (2) @(posedge CLK);
        RESET <= 1'b0;   // two cycles of reset
    end

    always #5 CLK = ~CLK;

endmodule

// File: verification/eeprom_bus_model.sv
module eeprom_bus_model (
    input  logic scl,
    inout  wire  sda,
    output int   frame_errors,
    output int   stop_count
);

    eeprom_pkg::eeprom_byte_t mem [0:2047];
    eeprom_pkg::eeprom_byte_t shift_reg;
    eeprom_pkg::eeprom_addr_t cur_addr;
    logic in_txn;
    logic restarted;
    logic have_addr;
    logic reading;
    logic drive_en;
    logic drive_bit;
    int   bit_cnt;
    int   byte_cnt;
    int   rd_bits;

    assign sda = drive_en ? drive_bit : 1'bz;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;   // erased array
        in_txn       = 1'b0;
        restarted    = 1'b0;
        have_addr    = 1'b0;
        reading      = 1'b0;
        drive_en     = 1'b0;
        drive_bit    = 1'b1;
        frame_errors = 0;
        stop_count   = 0;
    end

    task automatic bad_frame(input string msg);
        frame_errors++;
        $display("bus model at %0t: %s", $time, msg);
    endtask

    task automatic take_byte(input eeprom_pkg::eeprom_byte_t b);
        case (byte_cnt)
            0:
            begin
                if (b[7:4] != eeprom_pkg::DEV_PREFIX)
                    bad_frame("control byte does not carry the 1010 device prefix");
                if (b[0])
                begin
                    if (!restarted || !have_addr)
                        bad_frame("read without a preceding address");
                    else if (b[3:1] != cur_addr[10:8])
                        bad_frame("read control byte names a different block");
                    reading = 1'b1;
                    rd_bits = 0;
                end
                else
                begin
                    if (restarted)
                        bad_frame("write direction after a repeated start");
                    cur_addr[10:8] = b[3:1];
                end
            end
            1:
            begin
                cur_addr[7:0] = b;
                have_addr     = 1'b1;
            end
            2:
                mem[cur_addr] = b;
            default:
                bad_frame("more bytes than a single write allows");
        endcase
    endtask

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            if (in_txn)
            begin
                if (byte_cnt != 2 || !have_addr)
                    bad_frame("repeated start before the address was sent");
                restarted = 1'b1;
            end
            in_txn   = 1'b1;
            bit_cnt  = 0;
            byte_cnt = 0;
        end
    end

    // stop, idle stops after reset are ignored
    always @(posedge sda)
    begin
        if (scl === 1'b1 && in_txn)
        begin
            if (reading ? rd_bits != 8 : (byte_cnt != 3 || restarted))
                bad_frame("wrong frame count before stop");
            stop_count++;
            in_txn    = 1'b0;
            reading   = 1'b0;
            restarted = 1'b0;
            have_addr = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (in_txn && reading)
        begin
            if (rd_bits < 8)
                rd_bits++;
        end
        else if (in_txn)
        begin
            shift_reg = {shift_reg[6:0], sda};
            bit_cnt++;
            if (bit_cnt == 8)
            begin
                take_byte(shift_reg);
                bit_cnt = 0;
                byte_cnt++;
            end
        end
    end

    // read bits change only while scl is low
    always @(negedge scl)
    begin
        if (in_txn && reading && rd_bits < 8)
        begin
            drive_bit = mem[cur_addr][7 - rd_bits];
            drive_en  = 1'b1;
        end
        else
            drive_en = 1'b0;
    end

endmodule

// File: verification/tb_eeprom_ctrl.sv
module tb_eeprom_ctrl;

    localparam int SCL_HALF   = 1;
    localparam int N_RANDOM   = 200;
    localparam int N_CMDS     = N_RANDOM + 5;
    localparam int MAX_CYCLES = N_CMDS * 300 + 100;   // longest is a read

    logic                     CLK;
    logic                     RESET;
    logic                     wr;
    logic                     rd;
    eeprom_pkg::eeprom_addr_t addr;
    eeprom_pkg::eeprom_byte_t wr_data;
    eeprom_pkg::eeprom_byte_t rd_data;
    logic                     ack;
    logic                     scl;
    wire                      sda;

    eeprom_pkg::eeprom_byte_t shadow [0:2047];
    eeprom_pkg::eeprom_byte_t last_rd;
    logic [15:0]              lfsr;
    int                       errors;
    int                       checks;
    int                       cmds_done;
    int                       ack_pulses;
    int                       cycles;
    int                       frame_errors;
    int                       stop_count;

    pullup (sda);

    clk_reset_gen clk_gen (
        .CLK   (CLK),
        .RESET (RESET)
    );

    eeprom_ctrl_top #(
        .SCL_HALF (SCL_HALF)
    ) uut (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .scl     (scl),
        .sda     (sda)
    );

    eeprom_bus_model mem_model (
        .scl          (scl),
        .sda          (sda),
        .frame_errors (frame_errors),
        .stop_count   (stop_count)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("ERR t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    // called on a rising edge, returns on the edge after ack has dropped
    task automatic run_cmd(input logic w, input logic r, input eeprom_pkg::eeprom_addr_t a,
                           input eeprom_pkg::eeprom_byte_t d);
        wr      <= w;
        rd      <= r;
        addr    <= a;
        wr_data <= d;
        @(posedge CLK);
        while (ack !== 1'b1)
            @(posedge CLK);
        if (w)
        begin
            shadow[a] = d;   // write wins over rd
            check_value("rd_data", last_rd, rd_data);
        end
        else
        begin
            check_value("rd_data", shadow[a], rd_data);
            last_rd = shadow[a];
        end
        wr <= 1'b0;
        rd <= 1'b0;
        @(posedge CLK);
        check_value("ack", 0, ack);
        cmds_done++;
    endtask

    always @(posedge CLK)
    begin
        if (!RESET && ack === 1'b1)
            ack_pulses++;
    end

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    initial
    begin
        logic [15:0]              op;
        logic [15:0]              sel;
        logic [15:0]              val;
        eeprom_pkg::eeprom_addr_t a;
        int                       n;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wr_data    = '0;
        lfsr       = 16'd69;
        errors     = 0;
        checks     = 0;
        cmds_done  = 0;
        ack_pulses = 0;
        cycles     = 0;
        last_rd    = 'x;   // rd_data has no reset value
        for (n = 0; n < 2048; n++)
            shadow[n] = 8'hFF;

        @(posedge CLK);
        while (RESET)
            @(posedge CLK);
        check_value("ack", 0, ack);
        check_value("scl", 1, scl);
        check_value("sda", 1, sda);

        run_cmd(1'b1, 1'b0, 11'h123, 8'h5A);
        run_cmd(1'b0, 1'b1, 11'h123, 8'h00);
        run_cmd(1'b0, 1'b1, 11'h7FF, 8'h00);   // never written
        run_cmd(1'b1, 1'b1, 11'h456, 8'hC3);
        run_cmd(1'b0, 1'b1, 11'h456, 8'h00);

        for (n = 0; n < N_RANDOM; n++)
        begin
            take_bits(2, op);
            take_bits(4, sel);
            take_bits(8, val);
            a = {sel[3:1], 7'd0, sel[0]};   // 16 addresses over all blocks
            run_cmd(op == 0 || op == 3, op != 0, a, val[7:0]);
        end

        check_value("ack_pulses", cmds_done, ack_pulses);
        check_value("stop_count", cmds_done, stop_count);
        $display("checks %0d, value errors %0d, framing errors %0d",
                 checks, errors, frame_errors);
        if (errors == 0 && frame_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
